// File: build.f
+incdir+common
common/bk_audio_pkg.sv
source/bus_write_regs.sv
audio/channel_mix.sv
audio/stereo_blend.sv
source/bk_audio_top.sv
tests/tb_clock_gen.sv
tests/bk_audio_chk.sv
tests/bk_audio_checker.sv
tests/tb_bk_audio.sv

// File: Bender.yml
package:
  name: bk_audio

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bk_audio_pkg.sv
      - source/bus_write_regs.sv
      - audio/channel_mix.sv
      - audio/stereo_blend.sv
      - source/bk_audio_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_clock_gen.sv
      - tests/bk_audio_chk.sv
      - tests/bk_audio_checker.sv
      - tests/tb_bk_audio.sv

// File: tests/tb_bk_audio.sv
////////////////////////////////////////////////////////////////////////////
// Sound path testbench
// Drives bus writes, generator levels and mix settings into the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "bk_audio_params.svh"

module tb_bk_audio;

	import bk_audio_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int SPK_WRITES   = 24;
	localparam int PORT_WRITES  = 24;
	localparam int GEN_CYCLES   = 32;
	localparam int BLEND_STEPS  = 8;
	localparam int HOLD_ROUNDS  = 4;
	localparam int HOLD_LEN     = 5;
	localparam int DRAIN        = 4;
	localparam int TEST_CYCLES  = 2 * SPK_WRITES + 2 * PORT_WRITES + GEN_CYCLES
		+ 4 * BLEND_STEPS + 2 * HOLD_ROUNDS * (HOLD_LEN + 1) + 5 * (DRAIN + 1);
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

	logic                    clk_sys;
	logic                    reset;
	bus_wr_t                 bus;
	logic                    bk0010;
	logic                    covox_enable;
	psg_levels_t             psg;
	logic [1:0]              audio_mix;
	logic [`BK_SAMPLE_W-1:0] audio_l;
	logic [`BK_SAMPLE_W-1:0] audio_r;
	int                      test_num;
	logic                    done;
	int                      mismatches;
	int                      checks;
	int                      assert_fails;
	int                      cycle_count;
	logic [31:0]             lfsr_state;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_inst (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	bk_audio_top bk_audio_top_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.bk0010       (bk0010),
		.covox_enable (covox_enable),
		.psg          (psg),
		.audio_mix    (audio_mix),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	bk_audio_checker bk_audio_checker_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.bk0010       (bk0010),
		.covox_enable (covox_enable),
		.psg          (psg),
		.audio_mix    (audio_mix),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.test_num     (test_num),
		.done         (done),
		.mismatches   (mismatches),
		.checks       (checks)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// One strobe cycle then one idle cycle, all on falling edges
	task automatic bus_write(input logic sysreg, input logic [1:0] wtbt,
		input logic [15:0] data);
		@(negedge clk_sys);
		bus.sysreg_write = sysreg;
		bus.port_write   = ~sysreg;
		bus.wtbt         = wtbt;
		bus.data         = data;
		@(negedge clk_sys);
		bus.sysreg_write = 1'b0;
		bus.port_write   = 1'b0;
	endtask

	task automatic start_test(input int n);
		@(negedge clk_sys);
		test_num = n;
	endtask

	task automatic drain();
		repeat (DRAIN) @(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_speaker();
		logic [31:0] data;
		logic [31:0] wtbt;
		logic [31:0] bk;
		start_test(1);
		psg.active   = 1'b0;
		covox_enable = 1'b0;
		for (int i = 0; i < SPK_WRITES; i++) begin
			random_bits(16, data);
			random_bits(2, wtbt);
			bus_write(1'b1, wtbt[1:0], data[15:0]);
			random_bits(1, bk);
			bk0010 = bk[0];
		end
		drain();
	endtask

	task automatic test_covox();
		logic [31:0] data;
		start_test(2);
		covox_enable = 1'b1;
		bk0010       = 1'b0;
		for (int i = 0; i < PORT_WRITES; i++) begin
			random_bits(16, data);
			bus_write(1'b0, 2'(i), data[15:0]);
		end
		drain();
	endtask

	task automatic test_generator();
		logic [31:0] r;
		start_test(3);
		psg.active = 1'b1;
		for (int i = 0; i < GEN_CYCLES; i++) begin
			@(negedge clk_sys);
			random_bits(24, r);
			psg.a = r[23:16];
			psg.b = r[15:8];
			psg.c = r[7:0];
		end
		drain();
	endtask

	task automatic test_cross_mix();
		logic [31:0] r;
		start_test(4);
		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < BLEND_STEPS; i++) begin
				@(negedge clk_sys);
				random_bits(16, r);
				audio_mix = 2'(m);
				psg.a     = r[15:8];
				psg.b     = r[7:0];
				// Top bit flipped so left and right always differ
				psg.c     = r[15:8] ^ 8'h80;
			end
		end
		drain();
	endtask

	task automatic test_held_strobe();
		logic [31:0] data;
		start_test(5);
		psg.active   = 1'b0;
		covox_enable = 1'b1;
		audio_mix    = 2'd0;
		for (int r = 0; r < HOLD_ROUNDS; r++) begin
			for (int j = 0; j < HOLD_LEN; j++) begin
				@(negedge clk_sys);
				random_bits(16, data);
				bus.port_write = 1'b1;
				bus.wtbt       = 2'b11;
				bus.data       = data[15:0];
			end
			@(negedge clk_sys);
			bus.port_write = 1'b0;
			for (int j = 0; j < HOLD_LEN; j++) begin
				@(negedge clk_sys);
				random_bits(16, data);
				bus.sysreg_write = 1'b1;
				bus.wtbt         = 2'b01;
				bus.data         = data[15:0];
			end
			@(negedge clk_sys);
			bus.sysreg_write = 1'b0;
		end
		drain();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence and verdict

	initial begin
		bus          = '0;
		bk0010       = 1'b0;
		covox_enable = 1'b0;
		psg          = '0;
		audio_mix    = 2'd0;
		test_num     = 0;
		done         = 1'b0;
		cycle_count  = 0;
		lfsr_state   = 32'hce18af8d;
		wait (reset === 1'b0);
		test_speaker();
		test_covox();
		test_generator();
		test_cross_mix();
		test_held_strobe();
		@(negedge clk_sys);
		done = 1'b1;
		@(negedge clk_sys);
		@(negedge clk_sys);
		assert_fails = bk_audio_top_inst.bk_audio_chk_inst.fail_count;
		$display("Totals: %0d checks, %0d mismatches, %0d assertion failures",
			checks, mismatches, assert_fails);
		if (mismatches == 0 && assert_fails == 0 && checks > 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d cycles", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

// File: tests/bk_audio_checker.sv
////////////////////////////////////////////////////////////////////////////
// Sound path checker
// Models the write registers and both pipeline stages, compares the
// samples on every rising edge and reports each test
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "bk_audio_params.svh"

module bk_audio_checker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  bk_audio_pkg::bus_wr_t     bus,
	input  logic                      bk0010,
	input  logic                      covox_enable,
	input  bk_audio_pkg::psg_levels_t psg,
	input  logic [1:0]                audio_mix,
	input  logic [`BK_SAMPLE_W-1:0]   audio_l,
	input  logic [`BK_SAMPLE_W-1:0]   audio_r,
	input  int                        test_num,
	input  logic                      done,
	output int                        mismatches,
	output int                        checks
);

	import bk_audio_pkg::*;

	logic                    sys_prev;
	logic                    port_prev;
	logic [`BK_SPK_W-1:0]    spk_m;
	logic [`BK_DATA_W-1:0]   port_m;
	int                      level_l_m;
	int                      level_r_m;
	logic [`BK_SAMPLE_W-1:0] exp_l;
	logic [`BK_SAMPLE_W-1:0] exp_r;
	int                      cur_test;
	int                      test_checks;
	int                      test_errors;
	logic                    reported;

	function automatic int expected_level(input int main, input int shared,
		input logic active, input int covox_byte, input int spk, input logic cov_en);
		if (active)
			return main * 2 + shared + spk * 32;
		else if (cov_en)
			return spk * 64 + covox_byte * 2;
		return spk * 128;
	endfunction

	function automatic logic [`BK_SAMPLE_W-1:0] expected_sample(input int own,
		input int other, input logic [1:0] mix);
		int k;
		int level;
		k = (mix >= 2) ? 2 : int'(mix);
		level = (own * (4 - k) + other * k) / 4;
		return level << (`BK_SAMPLE_W - `BK_LEVEL_W);
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "speaker only";
			2: return "covox";
			3: return "generator active";
			4: return "cross-mix";
			5: return "held strobe";
			default: return "unnamed";
		endcase
	endfunction

	task automatic report_test();
		$display("Test %0d %s: %0d checks, %0d mismatches, %s", cur_test,
			test_name(cur_test), test_checks, test_errors,
			(test_errors == 0) ? "ok" : "failed");
	endtask

	initial begin
		mismatches  = 0;
		checks      = 0;
		cur_test    = 0;
		test_checks = 0;
		test_errors = 0;
		reported    = 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test bookkeeping, comparison and model

	always @(posedge clk_sys) begin
		if (test_num != cur_test) begin
			if (cur_test != 0)
				report_test();
			cur_test    = test_num;
			test_checks = 0;
			test_errors = 0;
		end
		if (done && !reported) begin
			report_test();
			reported = 1'b1;
		end

		if (reset) begin
			sys_prev  <= 1'b0;
			port_prev <= 1'b0;
			spk_m     <= '0;
			port_m    <= '0;
			level_l_m <= 0;
			level_r_m <= 0;
			exp_l     <= '0;
			exp_r     <= '0;
		end else begin
			// Outputs still hold the samples of the previous edge
			checks++;
			test_checks++;
			if (audio_l !== exp_l) begin
				$display("Mismatch audio_l: expected %h, got %h", exp_l, audio_l);
				mismatches++;
				test_errors++;
			end
			if (audio_r !== exp_r) begin
				$display("Mismatch audio_r: expected %h, got %h", exp_r, audio_r);
				mismatches++;
				test_errors++;
			end

			exp_l     <= expected_sample(level_l_m, level_r_m, audio_mix);
			exp_r     <= expected_sample(level_r_m, level_l_m, audio_mix);
			level_l_m <= expected_level(psg.a, psg.b, psg.active, port_m[7:0], spk_m,
				covox_enable);
			level_r_m <= expected_level(psg.c, psg.b, psg.active, port_m[15:8], spk_m,
				covox_enable);

			sys_prev  <= bus.sysreg_write;
			port_prev <= bus.port_write;
			if (bus.sysreg_write && !sys_prev && bus.wtbt[0]
				&& (!bus.wtbt[1] || !bus.data[11]))
				spk_m <= {bus.data[6], bus.data[5], bus.data[2] & ~bk0010};
			if (bus.port_write && !port_prev) begin
				if (bus.wtbt[0])
					port_m[7:0] <= bus.data[7:0];
				if (bus.wtbt[1])
					port_m[15:8] <= bus.data[15:8];
			end
		end
	end

endmodule

// File: tests/bk_audio_chk.sv
////////////////////////////////////////////////////////////////////////////
// Sound path assertions
// Reset state, sample alignment and mono output of the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "bk_audio_params.svh"

module bk_audio_chk (
	input logic                    clk_sys,
	input logic                    reset,
	input logic [1:0]              audio_mix,
	input logic [`BK_SAMPLE_W-1:0] audio_l,
	input logic [`BK_SAMPLE_W-1:0] audio_r
);

	localparam int PAD_W = `BK_SAMPLE_W - `BK_LEVEL_W;

	int fail_count = 0;

	// Samples come out of reset cleared
	reset_clears: assert property (@(posedge clk_sys)
		reset |=> (audio_l == '0) && (audio_r == '0))
	else begin
		fail_count++;
		$error("Samples were not cleared in the cycle after reset");
	end

	low_bits_zero: assert property (@(posedge clk_sys) disable iff (reset)
		(audio_l[PAD_W-1:0] == '0) && (audio_r[PAD_W-1:0] == '0))
	else begin
		fail_count++;
		$error("Mismatch sample low bits: audio_l %h audio_r %h",
			$sampled(audio_l), $sampled(audio_r));
	end

	// Settings 2 and 3 give an even split, so both sides match
	mono_equal: assert property (@(posedge clk_sys) disable iff (reset)
		audio_mix[1] |=> (audio_l == audio_r))
	else begin
		fail_count++;
		$error("Mismatch mono audio_l %h audio_r %h", $sampled(audio_l), $sampled(audio_r));
	end

endmodule

bind bk_audio_top bk_audio_chk bk_audio_chk_inst (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.audio_mix (audio_mix),
	.audio_l   (audio_l),
	.audio_r   (audio_r)
);

// File: tests/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Release on a falling edge, clear of the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

// File: source/bk_audio_top.sv
////////////////////////////////////////////////////////////////////////////
// BK sound path top
// Bus write registers feed two channel mixers, then the stereo blend
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "bk_audio_params.svh"

module bk_audio_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  bk_audio_pkg::bus_wr_t     bus,
	input  logic                      bk0010,
	input  logic                      covox_enable,
	input  bk_audio_pkg::psg_levels_t psg,
	input  logic [1:0]                audio_mix,
	output logic [`BK_SAMPLE_W-1:0]   audio_l,
	output logic [`BK_SAMPLE_W-1:0]   audio_r
);

	import bk_audio_pkg::*;

	logic [`BK_SPK_W-1:0]  spk;
	logic [`BK_DATA_W-1:0] port_data;
	level_t                levels [`BK_CHANNELS];

	bus_write_regs bus_write_regs_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.bk0010    (bk0010),
		.spk       (spk),
		.port_data (port_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Channel mixers, left takes level a and the low port byte

	genvar ch;
	generate
		for (ch = 0; ch < `BK_CHANNELS; ch++) begin : g_chan
			mix_in_t mix_in;

			assign mix_in = '{
				main:         (ch == 0) ? psg.a : psg.c,
				shared:       psg.b,
				active:       psg.active,
				covox_byte:   port_data[ch*(`BK_DATA_W/2) +: (`BK_DATA_W/2)],
				spk:          spk,
				covox_enable: covox_enable
			};

			channel_mix channel_mix_inst (
				.clk_sys (clk_sys),
				.reset   (reset),
				.mix_in  (mix_in),
				.level   (levels[ch])
			);
		end
	endgenerate

	stereo_blend stereo_blend_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.level_l   (levels[0]),
		.level_r   (levels[1]),
		.audio_mix (audio_mix),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

endmodule

// File: audio/stereo_blend.sv
////////////////////////////////////////////////////////////////////////////
// Stereo blend
// Applies the four-step cross-mix and widens both levels to 16-bit samples
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "bk_audio_params.svh"

module stereo_blend (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  bk_audio_pkg::level_t     level_l,
	input  bk_audio_pkg::level_t     level_r,
	input  logic [1:0]               audio_mix,
	output logic [`BK_SAMPLE_W-1:0]  audio_l,
	output logic [`BK_SAMPLE_W-1:0]  audio_r
);

	import bk_audio_pkg::*;

	localparam int SUM_W = `BK_LEVEL_W + 2;

	// Cross weight k in quarters, own weight is 4 - k
	logic [1:0]       k;
	logic [2:0]       own_w;
	logic [SUM_W-1:0] sum_l;
	logic [SUM_W-1:0] sum_r;
	level_t           blend_l;
	level_t           blend_r;

	// Settings 2 and 3 both land on an even split
	assign k     = audio_mix[1] ? 2'd2 : {1'b0, audio_mix[0]};
	assign own_w = 3'd4 - {1'b0, k};

	always_comb begin
		sum_l = SUM_W'(level_l) * SUM_W'(own_w) + SUM_W'(level_r) * SUM_W'(k);
		sum_r = SUM_W'(level_r) * SUM_W'(own_w) + SUM_W'(level_l) * SUM_W'(k);
	end

	// Divide by four, remainder dropped
	assign blend_l = sum_l[SUM_W-1:2];
	assign blend_r = sum_r[SUM_W-1:2];

	////////////////////////////////////////////////////////////////////////////
	// Sample registers

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			// Level goes in the top bits, unsigned
			audio_l <= {blend_l, {(`BK_SAMPLE_W - `BK_LEVEL_W){1'b0}}};
			audio_r <= {blend_r, {(`BK_SAMPLE_W - `BK_LEVEL_W){1'b0}}};
		end
	end

endmodule

// File: audio/channel_mix.sv
////////////////////////////////////////////////////////////////////////////
// Channel mixer
// Combines generator levels, speaker bits and one covox byte into a
// registered 10-bit channel level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module channel_mix (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  bk_audio_pkg::mix_in_t mix_in,
	output bk_audio_pkg::level_t  level
);

	import bk_audio_pkg::*;

	level_t level_next;

	// Source select
	always_comb begin
		if (mix_in.active) begin
			// Generator running, speaker rides on top at a quarter weight
			level_next = {1'b0, mix_in.main, 1'b0}
			           + {2'b00, mix_in.shared}
			           + {2'b00, mix_in.spk, 5'b00000};
		end else if (mix_in.covox_enable) begin
			level_next = {1'b0, mix_in.spk, 6'b000000}
			           + {1'b0, mix_in.covox_byte, 1'b0};
		end else begin
			// Speaker alone uses the full range
			level_next = {mix_in.spk, 7'b0000000};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clk_sys) begin
		if (reset)
			level <= '0;
		else
			level <= level_next;
	end

endmodule

// File: source/bus_write_regs.sv
////////////////////////////////////////////////////////////////////////////
// Bus write registers
// Captures the speaker bits from system register writes and the two
// covox bytes from parallel port writes, once per strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "bk_audio_params.svh"

module bus_write_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  bk_audio_pkg::bus_wr_t  bus,
	input  logic                   bk0010,
	output logic [`BK_SPK_W-1:0]   spk,
	output logic [`BK_DATA_W-1:0]  port_data
);

	// Previous strobe levels for edge detection
	logic sysreg_prev;
	logic port_prev;
	logic sysreg_rise;
	logic port_rise;
	logic spk_take;

	assign sysreg_rise = bus.sysreg_write & ~sysreg_prev;
	assign port_rise   = bus.port_write & ~port_prev;

	// Low byte enabled, and the high byte either absent or not holding keep
	assign spk_take = bus.wtbt[0] & (~bus.wtbt[1] | ~bus.data[`BK_WTBT_HI_KEEP]);

	////////////////////////////////////////////////////////////////////////////
	// Strobe history

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sysreg_prev <= 1'b0;
			port_prev   <= 1'b0;
		end else begin
			sysreg_prev <= bus.sysreg_write;
			port_prev   <= bus.port_write;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Speaker and covox port

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			spk       <= '0;
			port_data <= '0;
		end else begin
			if (sysreg_rise && spk_take) begin
				// Bit 0 does not exist on the BK0010
				spk <= {bus.data[`BK_SPK_BIT2],
				        bus.data[`BK_SPK_BIT1],
				        bus.data[`BK_SPK_BIT0] & ~bk0010};
			end
			if (port_rise) begin
				if (bus.wtbt[0])
					port_data[`BK_DATA_W/2-1:0] <= bus.data[`BK_DATA_W/2-1:0];
				if (bus.wtbt[1])
					port_data[`BK_DATA_W-1:`BK_DATA_W/2] <= bus.data[`BK_DATA_W-1:`BK_DATA_W/2];
			end
		end
	end

endmodule

// File: common/bk_audio_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Sound path types
// Bus write cycle, generator levels, mixer input and channel level
////////////////////////////////////////////////////////////////////////////

`include "bk_audio_params.svh"

package bk_audio_pkg;

	// One CPU bus write as seen by the register block
	typedef struct packed {
		logic                  sysreg_write;
		logic                  port_write;
		logic [1:0]            wtbt;
		logic [`BK_DATA_W-1:0] data;
	} bus_wr_t;

	// Sound generator outputs
	typedef struct packed {
		logic [`BK_PSG_W-1:0] a;
		logic [`BK_PSG_W-1:0] b;
		logic [`BK_PSG_W-1:0] c;
		logic                 active;
	} psg_levels_t;

	// Everything one channel mixer needs
	typedef struct packed {
		logic [`BK_PSG_W-1:0]    main;
		logic [`BK_PSG_W-1:0]    shared;
		logic                    active;
		logic [`BK_DATA_W/2-1:0] covox_byte;
		logic [`BK_SPK_W-1:0]    spk;
		logic                    covox_enable;
	} mix_in_t;

	typedef logic [`BK_LEVEL_W-1:0] level_t;

endpackage

// File: common/bk_audio_params.svh
////////////////////////////////////////////////////////////////////////////
// Sound path widths and bus bit positions
// Shared by the package, the write register block and the audio stages
////////////////////////////////////////////////////////////////////////////

`ifndef BK_AUDIO_PARAMS_SVH
`define BK_AUDIO_PARAMS_SVH

// Datapath widths
`define BK_DATA_W    16
`define BK_LEVEL_W   10
`define BK_SAMPLE_W  16
`define BK_PSG_W     8
`define BK_SPK_W     3

// High byte write with this bit set leaves the speaker alone
`define BK_WTBT_HI_KEEP  11

// Speaker bits in the system register word
`define BK_SPK_BIT2  6
`define BK_SPK_BIT1  5
`define BK_SPK_BIT0  2

// Left and right
`define BK_CHANNELS  2

`endif
